// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

verilator --binary --assert -Wno-fatal -f verilog.f --top-module ooo_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vooo_core_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// ==== verification/ooo_core_tb.sv ====
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_core_tb;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int CLK_PERIOD       = 100;
    localparam int PROG_MAX         = 128;
    localparam int CYCLES_PER_INSTR = 200;

    // expected retirement kinds
    localparam logic [1:0] K_NONE     = 2'd0;
    localparam logic [1:0] K_COMMIT   = 2'd1;
    localparam logic [1:0] K_STORE    = 2'd2;
    localparam logic [1:0] K_REDIRECT = 2'd3;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      instr_ready;
    commit_t   commit;
    store_t    store;
    redirect_t redirect;

    instr_t             prog   [PROG_MAX];
    logic               no_gap [PROG_MAX];
    int                 prog_len;
    logic               burst_mode;
    logic [1:0]         ev_kind [256];
    logic [`DATA_W-1:0] ev_key  [256];
    logic [`DATA_W-1:0] ev_data [256];
    int                 ev_total;
    logic [7:0]         ev_idx;
    logic [1:0]         exp_kind;
    logic [`DATA_W-1:0] exp_key;
    logic [`DATA_W-1:0] exp_data;
    rob_tag_t           alloc_count;
    rob_tag_t           tag_mem [256];
    logic [7:0]         tag_wr;
    logic [7:0]         tag_rd;
    rob_tag_t           exp_tag;
    logic [31:0]        lfsr;
    logic [`DATA_W-1:0] fetch_pc;
    int                 gap_left;
    logic               stall_seen;
    logic               ref_ready;
    int                 errors;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    ooo_core UUT (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .commit(commit), .store(store), .redirect(redirect)
    );

    // head of the expected retirement stream
    assign exp_kind = ev_kind[ev_idx];
    assign exp_key  = ev_key[ev_idx];
    assign exp_data = ev_data[ev_idx];
    assign exp_tag  = tag_mem[tag_rd];

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic append_instr(input opcode_t op, input int rd, input int rs1, input int rs2,
                                input logic [31:0] imm, input logic pred);
        instr_t ins;
        ins.op               = op;
        ins.rd               = reg_idx_t'(rd);
        ins.rs1              = reg_idx_t'(rs1);
        ins.rs2              = reg_idx_t'(rs2);
        ins.imm              = imm;
        ins.pc               = 32'(prog_len * 4);
        ins.pred_taken       = pred;
        prog[prog_len]       = ins;
        no_gap[prog_len]     = burst_mode;
        prog_len++;
    endtask

    task automatic build_programs();
        int op_sel;
        int rd;
        int rs1;
        int rs2;
        logic [31:0] imm;
        prog_len   = 0;
        burst_mode = 1'b0;
        // dependent chain, then a write to x0
        append_instr(op_addi, 1, 0, 0, 32'd5, 1'b0);
        append_instr(op_addi, 2, 1, 0, 32'd3, 1'b0);
        append_instr(op_add, 3, 2, 1, 32'd0, 1'b0);
        append_instr(op_add, 4, 3, 3, 32'd0, 1'b0);
        append_instr(op_sub, 5, 4, 1, 32'd0, 1'b0);
        append_instr(op_addi, 0, 5, 0, 32'd7, 1'b0);
        // alu mix over x0..x7
        for (int i = 0; i < 10; i++) begin
            op_sel = int'(next_bits(3)) % 5;
            rd     = int'(next_bits(3));
            rs1    = int'(next_bits(3));
            rs2    = int'(next_bits(3));
            imm    = next_bits(8);
            append_instr(opcode_t'(op_sel), rd, rs1, rs2, imm, 1'b0);
        end
        append_instr(op_sw, 0, 1, 4, 32'd16, 1'b0);
        append_instr(op_addi, 6, 0, 0, 32'd100, 1'b0);
        append_instr(op_sw, 0, 6, 3, 32'd8, 1'b0);
        // taken but predicted not taken with two wrong-path entries
        append_instr(op_beq, 0, 0, 0, 32'd12, 1'b0);
        append_instr(op_addi, 6, 0, 0, 32'd111, 1'b0);
        append_instr(op_addi, 7, 0, 0, 32'd222, 1'b0);
        append_instr(op_add, 6, 1, 2, 32'd0, 1'b0);
        append_instr(op_bne, 0, 0, 0, 32'd8, 1'b0);
        append_instr(op_addi, 7, 6, 0, 32'd1, 1'b0);
        // predicted taken and taken so fetch skips both stores
        append_instr(op_beq, 0, 0, 0, 32'd12, 1'b1);
        append_instr(op_sw, 0, 0, 7, 32'd64, 1'b0);
        append_instr(op_sw, 0, 0, 6, 32'd68, 1'b0);
        // predicted taken, falls through
        append_instr(op_bne, 0, 0, 0, 32'd12, 1'b1);
        append_instr(op_xor, 5, 6, 7, 32'd0, 1'b0);
        append_instr(op_sw, 0, 5, 5, 32'd0, 1'b0);
        append_instr(op_addi, 3, 0, 0, 32'd9, 1'b0);
        rs1 = int'(next_bits(3));
        rs2 = int'(next_bits(3));
        append_instr(op_beq, 0, rs1, rs2, 32'd8, 1'b0);
        append_instr(op_addi, 4, 4, 0, 32'd1, 1'b0);
        burst_mode = 1'b1;
        for (int i = 0; i < `ROB_DEPTH + 4; i++) begin
            append_instr(op_addi, (i % 7) + 1, 0, 0, 32'(i + 1), 1'b0);
        end
        burst_mode = 1'b0;
        append_instr(op_sw, 0, 0, 1, 32'd128, 1'b0);
    endtask

    task automatic expect_event(input logic [1:0] kind, input logic [31:0] key,
                                input logic [31:0] data);
        ev_kind[ev_total[7:0]] = kind;
        ev_key[ev_total[7:0]]  = key;
        ev_data[ev_total[7:0]] = data;
        ev_total++;
    endtask

    // architectural execution of the program table
    task automatic run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        taken;
        instr_t      ins;
        int          steps;
        for (int i = 0; i < 256; i++) begin
            ev_kind[i] = K_NONE;
            ev_key[i]  = '0;
            ev_data[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        ev_total = 0;
        pc       = '0;
        steps    = 0;
        while (int'(pc >> 2) < prog_len && steps < 1000) begin
            ins     = prog[pc[8:2]];
            a       = regs[ins.rs1];
            b       = regs[ins.rs2];
            next_pc = ins.pc + 32'd4;
            case (ins.op)
                op_sw: expect_event(K_STORE, a + ins.imm, b);
                op_beq, op_bne: begin
                    taken = (ins.op == op_beq) ? (a == b) : (a != b);
                    if (taken) begin
                        next_pc = ins.pc + ins.imm;
                    end
                    if (taken != ins.pred_taken) begin
                        expect_event(K_REDIRECT, next_pc, '0);
                    end
                end
                default: begin
                    case (ins.op)
                        op_add:  val = a + b;
                        op_sub:  val = a - b;
                        op_and:  val = a & b;
                        op_xor:  val = a ^ b;
                        default: val = a + ins.imm;
                    endcase
                    if (ins.rd != '0) begin
                        regs[ins.rd] = val;
                        expect_event(K_COMMIT, 32'(ins.rd), val);
                    end
                end
            endcase
            pc = next_pc;
            steps++;
        end
    endtask

    // fetch follows predictions and redirects
    always @(posedge clk) begin
        if (!rst) begin
            if (redirect.valid) begin
                fetch_pc = redirect.pc;
                gap_left = 0;
            end else if (instr_valid && instr_ready) begin
                fetch_pc = instr.pred_taken ? instr.pc + instr.imm : instr.pc + 32'd4;
                if (!no_gap[instr.pc[8:2]] && next_bits(2) == 32'd0) begin
                    gap_left = int'(next_bits(2));
                end
            end
            if (instr_valid && !instr_ready && !redirect.valid) begin
                stall_seen = 1'b1;
            end
            if (gap_left > 0) begin
                instr_valid <= 1'b0;
                gap_left--;
            end else if (int'(fetch_pc >> 2) < prog_len) begin
                instr_valid <= 1'b1;
                instr       <= prog[fetch_pc[8:2]];
            end else begin
                instr_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && (commit.valid || store.valid || redirect.valid)) begin
            ev_idx <= ev_idx + 8'd1;
        end
    end

    // tags follow acceptance order and restart at zero after a flush
    always @(posedge clk) begin
        if (rst) begin
            alloc_count <= '0;
            tag_wr      <= '0;
            tag_rd      <= '0;
        end else if (redirect.valid) begin
            alloc_count <= '0;
            tag_rd      <= tag_wr;
        end else begin
            if (instr_valid && instr_ready) begin
                alloc_count <= alloc_count + 1'b1;
                if (instr.rd != '0 && !(instr.op inside {op_beq, op_bne, op_sw})) begin
                    tag_mem[tag_wr] <= alloc_count;
                    tag_wr          <= tag_wr + 8'd1;
                end
            end
            if (commit.valid) begin
                tag_rd <= tag_rd + 8'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({commit.valid, store.valid, redirect.valid}))
        else flag_error("more than one retirement pulse in a cycle");

    assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> exp_kind == K_COMMIT && `DATA_W'(commit.rd) == exp_key
            && commit.value == exp_data)
        else flag_error("commit differs from the reference model");

    assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.tag == exp_tag)
        else flag_error("commit tag differs from the acceptance order");

    assert property (@(posedge clk) disable iff (rst)
        store.valid |-> exp_kind == K_STORE && store.addr == exp_key
            && store.data == exp_data)
        else flag_error("store differs from the reference model");

    assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> exp_kind == K_REDIRECT && redirect.pc == exp_key)
        else flag_error("redirect differs from the reference model");

    // buffer is empty right after a flush
    assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !commit.valid && !store.valid)
        else flag_error("retirement in the cycle after a redirect");

    assert property (@(posedge clk) $fell(rst) |-> instr_ready)
        else flag_error("instr_ready low after reset");

    initial begin
        wait (ref_ready);
        #(prog_len * CYCLES_PER_INSTR * CLK_PERIOD);
        $display("timeout: %0d of %0d expected events seen, %0d errors",
                 ev_idx, ev_total, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'h8d67;
        fetch_pc    = '0;
        gap_left    = 0;
        stall_seen  = 1'b0;
        errors      = 0;
        ev_idx      = '0;
        ref_ready   = 1'b0;
        build_programs();
        run_reference();
        ref_ready = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait (int'(ev_idx) == ev_total);
        // late or duplicated pulses still hit the assertions
        repeat (10) @(posedge clk);
        if (!stall_seen) begin
            errors++;
            $display("instr_ready never dropped while an instruction was waiting");
        end
        $display("%0d of %0d expected events seen, %0d errors", ev_idx, ev_total, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/rob_pkg.sv
verilog/reorder_buffer.sv
verilog/rename_file.sv
verilog/dispatch_unit.sv
verilog/exec_unit.sv
verilog/ooo_core.sv
verification/tb_clock.sv
verification/ooo_core_tb.sv

// ==== verilog/dispatch_unit.sv ====
`timescale 1ns/1ns
`include "ooo_defines.svh"

module dispatch_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  isa_pkg::instr_t    instr,
    output logic               instr_ready,
    output isa_pkg::reg_idx_t  src_a,
    output isa_pkg::reg_idx_t  src_b,
    input  logic [`DATA_W-1:0] val_a,
    input  logic [`DATA_W-1:0] val_b,
    input  logic               busy_a,
    input  logic               busy_b,
    input  rob_pkg::rob_tag_t  tag_a,
    input  rob_pkg::rob_tag_t  tag_b,
    output logic               rename_valid,
    output isa_pkg::reg_idx_t  rename_rd,
    output rob_pkg::rob_tag_t  rename_tag,
    output rob_pkg::rob_tag_t  query_tag_a,
    output rob_pkg::rob_tag_t  query_tag_b,
    input  logic               query_done_a,
    input  logic               query_done_b,
    input  logic [`DATA_W-1:0] query_value_a,
    input  logic [`DATA_W-1:0] query_value_b,
    output logic               alloc_valid,
    output rob_pkg::alloc_t    alloc,
    input  rob_pkg::rob_tag_t  alloc_tag,
    input  logic               rob_full,
    input  rob_pkg::complete_t complete,
    input  logic               flush,
    output logic               issue_valid,
    output rob_pkg::issue_t    issue
);
    import isa_pkg::*;

    logic               fwd_a, fwd_b;
    logic               ready_a, ready_b;
    logic               fire, writes_rd;
    logic [`DATA_W-1:0] opnd_a, opnd_b;

    assign src_a       = instr.rs1;
    assign src_b       = instr.rs2;
    assign query_tag_a = tag_a;
    assign query_tag_b = tag_b;

    // same-cycle writeback bypass
    assign fwd_a   = complete.valid && (complete.tag == tag_a);
    assign fwd_b   = complete.valid && (complete.tag == tag_b);
    assign ready_a = !busy_a || query_done_a || fwd_a;
    assign ready_b = !uses_rs2(instr.op) || !busy_b || query_done_b || fwd_b;

    // register file, then rob entry, then bypass
    assign opnd_a = !busy_a ? val_a : (query_done_a ? query_value_a : complete.value);
    assign opnd_b = !busy_b ? val_b : (query_done_b ? query_value_b : complete.value);

    assign instr_ready = !rob_full && ready_a && ready_b && !flush;
    assign fire        = instr_valid && instr_ready;
    assign writes_rd   = (instr.rd != '0) && !is_branch(instr.op) && !is_store(instr.op);

    assign alloc_valid      = fire;
    assign alloc.rd         = writes_rd ? instr.rd : '0;
    assign alloc.is_branch  = is_branch(instr.op);
    assign alloc.is_store   = is_store(instr.op);
    assign alloc.pred_taken = instr.pred_taken;
    assign alloc.pc         = instr.pc;

    assign rename_valid = fire && writes_rd;
    assign rename_rd    = instr.rd;
    assign rename_tag   = alloc_tag;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue.tag        <= alloc_tag;
            issue.op         <= instr.op;
            issue.a          <= opnd_a;
            issue.b          <= opnd_b;
            issue.imm        <= instr.imm;
            issue.pc         <= instr.pc;
            issue.pred_taken <= instr.pred_taken;
        end
    end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ns
`include "ooo_defines.svh"

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  rob_pkg::issue_t    issue,
    input  logic               flush,
    output rob_pkg::complete_t complete
);
    import isa_pkg::*;
    import rob_pkg::*;

    logic [`DATA_W-1:0] alu_out;
    logic               taken;
    complete_t          s1_next;
    complete_t          s1;

    always_comb begin
        alu_out = '0;
        taken   = 1'b0;
        case (issue.op)
            op_add:  alu_out = issue.a + issue.b;
            op_sub:  alu_out = issue.a - issue.b;
            op_and:  alu_out = issue.a & issue.b;
            op_xor:  alu_out = issue.a ^ issue.b;
            op_addi: alu_out = issue.a + issue.imm;
            op_beq:  taken = (issue.a == issue.b);
            op_bne:  taken = (issue.a != issue.b);
            // store data rides in value
            op_sw:   alu_out = issue.b;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        s1_next.valid      = issue_valid;
        s1_next.tag        = issue.tag;
        s1_next.value      = alu_out;
        s1_next.addr       = '0;
        s1_next.mispredict = 1'b0;
        if (is_branch(issue.op)) begin
            s1_next.addr       = taken ? issue.pc + issue.imm : issue.pc + `DATA_W'(4);
            s1_next.mispredict = (taken != issue.pred_taken);
        end else if (is_store(issue.op)) begin
            s1_next.addr = issue.a + issue.imm;
        end
    end

    // flush drops both stages
    always_ff @(posedge clk) begin
        s1       <= s1_next;
        complete <= s1;
        if (rst || flush) begin
            s1.valid       <= 1'b0;
            complete.valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/isa_pkg.sv ====
`include "ooo_defines.svh"

package isa_pkg;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_xor  = 4'd3,
        op_addi = 4'd4,
        op_beq  = 4'd5,
        op_bne  = 4'd6,
        op_sw   = 4'd7
    } opcode_t;

    typedef logic [`REG_AW-1:0] reg_idx_t;

    typedef struct packed {
        opcode_t            op;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        reg_idx_t           rs2;
        logic [`DATA_W-1:0] imm;
        logic [`DATA_W-1:0] pc;
        logic               pred_taken;
    } instr_t;

    function automatic logic is_branch(opcode_t op);
        return (op == op_beq) || (op == op_bne);
    endfunction

    function automatic logic is_store(opcode_t op);
        return op == op_sw;
    endfunction

    // addi is the only op without a second register source
    function automatic logic uses_rs2(opcode_t op);
        return op != op_addi;
    endfunction

endpackage

// ==== verilog/ooo_core.sv ====
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  isa_pkg::instr_t    instr,
    output logic               instr_ready,
    output rob_pkg::commit_t   commit,
    output rob_pkg::store_t    store,
    output rob_pkg::redirect_t redirect
);
    import isa_pkg::*;
    import rob_pkg::*;

    reg_idx_t           src_a, src_b, rename_rd;
    logic [`DATA_W-1:0] val_a, val_b;
    logic [`DATA_W-1:0] query_value_a, query_value_b;
    logic               busy_a, busy_b;
    logic               query_done_a, query_done_b;
    logic               rename_valid, alloc_valid, rob_full, issue_valid;
    rob_tag_t           tag_a, tag_b, query_tag_a, query_tag_b;
    rob_tag_t           rename_tag, alloc_tag;
    alloc_t             alloc;
    issue_t             issue;
    complete_t          complete;
    logic               flush;

    // mispredict at the head flushes everything
    assign flush = redirect.valid;

    dispatch_unit u_dispatch (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .src_a(src_a), .src_b(src_b), .val_a(val_a), .val_b(val_b),
        .busy_a(busy_a), .busy_b(busy_b), .tag_a(tag_a), .tag_b(tag_b),
        .rename_valid(rename_valid), .rename_rd(rename_rd), .rename_tag(rename_tag),
        .query_tag_a(query_tag_a), .query_tag_b(query_tag_b),
        .query_done_a(query_done_a), .query_done_b(query_done_b),
        .query_value_a(query_value_a), .query_value_b(query_value_b),
        .alloc_valid(alloc_valid), .alloc(alloc), .alloc_tag(alloc_tag),
        .rob_full(rob_full), .complete(complete), .flush(flush),
        .issue_valid(issue_valid), .issue(issue)
    );

    rename_file u_rename (
        .clk(clk), .rst(rst),
        .src_a(src_a), .src_b(src_b), .val_a(val_a), .val_b(val_b),
        .busy_a(busy_a), .busy_b(busy_b), .tag_a(tag_a), .tag_b(tag_b),
        .rename_valid(rename_valid), .rename_rd(rename_rd), .rename_tag(rename_tag),
        .commit(commit), .flush(flush)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst),
        .alloc_valid(alloc_valid), .alloc(alloc), .alloc_tag(alloc_tag),
        .rob_full(rob_full),
        .query_tag_a(query_tag_a), .query_tag_b(query_tag_b),
        .query_done_a(query_done_a), .query_done_b(query_done_b),
        .query_value_a(query_value_a), .query_value_b(query_value_b),
        .complete(complete), .commit(commit), .store(store), .redirect(redirect)
    );

    exec_unit u_exec (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue(issue),
        .flush(flush), .complete(complete)
    );

endmodule

// ==== verilog/ooo_defines.svh ====
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// width of data, pc and addresses
`define DATA_W 32

// architectural registers with x0 hardwired to zero
`define NUM_REGS 32
`define REG_AW $clog2(`NUM_REGS)

// reorder buffer entries as a power of two
`define ROB_DEPTH 16
`define TAG_W $clog2(`ROB_DEPTH)

`endif

// ==== verilog/rename_file.sv ====
`timescale 1ns/1ns
`include "ooo_defines.svh"

module rename_file (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::reg_idx_t  src_a,
    input  isa_pkg::reg_idx_t  src_b,
    output logic [`DATA_W-1:0] val_a,
    output logic [`DATA_W-1:0] val_b,
    output logic               busy_a,
    output logic               busy_b,
    output rob_pkg::rob_tag_t  tag_a,
    output rob_pkg::rob_tag_t  tag_b,
    input  logic               rename_valid,
    input  isa_pkg::reg_idx_t  rename_rd,
    input  rob_pkg::rob_tag_t  rename_tag,
    input  rob_pkg::commit_t   commit,
    input  logic               flush
);
    import rob_pkg::*;

    logic [`DATA_W-1:0]   regs [`NUM_REGS];
    logic [`NUM_REGS-1:0] busy;
    rob_tag_t             tags [`NUM_REGS];

    assign val_a  = regs[src_a];
    assign val_b  = regs[src_b];
    assign busy_a = busy[src_a];
    assign busy_b = busy[src_b];
    assign tag_a  = tags[src_a];
    assign tag_b  = tags[src_b];

    // architectural state starts from zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value;
        end
    end

    // later rename overrides the commit clear
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (commit.valid && tags[commit.rd] == commit.tag) begin
                busy[commit.rd] <= 1'b0;
            end
            if (rename_valid) begin
                busy[rename_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_valid) begin
            tags[rename_rd] <= rename_tag;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !busy[0]);

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/1ns
`include "ooo_defines.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  rob_pkg::alloc_t    alloc,
    output rob_pkg::rob_tag_t  alloc_tag,
    output logic               rob_full,
    input  rob_pkg::rob_tag_t  query_tag_a,
    input  rob_pkg::rob_tag_t  query_tag_b,
    output logic               query_done_a,
    output logic               query_done_b,
    output logic [`DATA_W-1:0] query_value_a,
    output logic [`DATA_W-1:0] query_value_b,
    input  rob_pkg::complete_t complete,
    output rob_pkg::commit_t   commit,
    output rob_pkg::store_t    store,
    output rob_pkg::redirect_t redirect
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int COUNT_W = `TAG_W + 1;

    logic [`ROB_DEPTH-1:0] occupied;
    logic [`ROB_DEPTH-1:0] done;

    // entry payload
    logic [`ROB_DEPTH-1:0] is_branch_q;
    logic [`ROB_DEPTH-1:0] is_store_q;
    logic [`ROB_DEPTH-1:0] mispredict_q;
    reg_idx_t              rd_mem    [`ROB_DEPTH];
    logic [`DATA_W-1:0]    value_mem [`ROB_DEPTH];
    logic [`DATA_W-1:0]    addr_mem  [`ROB_DEPTH];

    rob_tag_t           head;
    rob_tag_t           tail;
    logic [COUNT_W-1:0] count;
    logic               retire;

    assign alloc_tag = tail;
    assign rob_full  = (count == COUNT_W'(`ROB_DEPTH));
    assign retire    = occupied[head] && done[head];

    assign query_done_a  = occupied[query_tag_a] && done[query_tag_a];
    assign query_done_b  = occupied[query_tag_b] && done[query_tag_b];
    assign query_value_a = value_mem[query_tag_a];
    assign query_value_b = value_mem[query_tag_b];

    // stores and branches retire without a register write
    always_comb begin
        commit   = '0;
        store    = '0;
        redirect = '0;
        if (retire) begin
            if (is_store_q[head]) begin
                store.valid = 1'b1;
                store.addr  = addr_mem[head];
                store.data  = value_mem[head];
            end else if (is_branch_q[head]) begin
                redirect.valid = mispredict_q[head];
                redirect.pc    = addr_mem[head];
            end else if (rd_mem[head] != '0) begin
                commit.valid = 1'b1;
                commit.tag   = head;
                commit.rd    = rd_mem[head];
                commit.value = value_mem[head];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect.valid) begin
            occupied <= '0;
            done     <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (alloc_valid) begin
                occupied[tail] <= 1'b1;
                done[tail]     <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (complete.valid) begin
                done[complete.tag] <= 1'b1;
            end
            if (retire) begin
                occupied[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            case ({alloc_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_mem[tail]      <= alloc.rd;
            is_branch_q[tail] <= alloc.is_branch;
            is_store_q[tail]  <= alloc.is_store;
        end
        if (complete.valid) begin
            value_mem[complete.tag]    <= complete.value;
            addr_mem[complete.tag]     <= complete.addr;
            mispredict_q[complete.tag] <= complete.mispredict;
        end
    end

    // dispatch must honour rob_full
    assert property (@(posedge clk) disable iff (rst) alloc_valid |-> !rob_full);

    // writeback lands on a live entry exactly once
    assert property (@(posedge clk) disable iff (rst)
        complete.valid |-> occupied[complete.tag] && !done[complete.tag]);

endmodule

// ==== verilog/rob_pkg.sv ====
`include "ooo_defines.svh"

package rob_pkg;

    typedef logic [`TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        isa_pkg::reg_idx_t  rd;
        logic               is_branch;
        logic               is_store;
        logic               pred_taken;
        logic [`DATA_W-1:0] pc;
    } alloc_t;

    typedef struct packed {
        rob_tag_t           tag;
        isa_pkg::opcode_t   op;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] imm;
        logic [`DATA_W-1:0] pc;
        logic               pred_taken;
    } issue_t;

    // value is the store data for stores, addr is target or store address
    typedef struct packed {
        logic               valid;
        rob_tag_t           tag;
        logic [`DATA_W-1:0] value;
        logic [`DATA_W-1:0] addr;
        logic               mispredict;
    } complete_t;

    typedef struct packed {
        logic               valid;
        rob_tag_t           tag;
        isa_pkg::reg_idx_t  rd;
        logic [`DATA_W-1:0] value;
    } commit_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } store_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] pc;
    } redirect_t;

endpackage
